/* aluAdder.sv */
// shared 64/32-bit adder-subtractor of the ALU core, returns sum plus carry, overflow and aux
`default_nettype none
`timescale 1ns/10ps

`include "intAlu_settings.svh"

module aluAdder (
  input  logic [`ALU_DATA_WIDTH-1:0] a,
  input  logic [`ALU_DATA_WIDTH-1:0] b,
  input  logic                       isSub,
  input  logic                       is32,
  output logic [`ALU_DATA_WIDTH-1:0] sum,
  output logic                       carry,
  output logic                       overflow,
  output logic                       auxCarry
);

  localparam int DW = `ALU_DATA_WIDTH;
  localparam int HW = `ALU_HALF_WIDTH;

  logic [DW-1:0] bOp;
  logic [DW:0]   full;
  logic [HW:0]   low;  // separate 32-bit carry chain
  logic [4:0]    nib;
  logic          ovf64;
  logic          ovf32;

  assign bOp = isSub ? ~b : b; // a - b as a + ~b + 1

  assign full = {1'b0, a} + {1'b0, bOp} + {{DW{1'b0}}, isSub};
  assign low = {1'b0, a[HW-1:0]} + {1'b0, bOp[HW-1:0]} + {{HW{1'b0}}, isSub};
  assign nib = {1'b0, a[3:0]} + {1'b0, bOp[3:0]} + {4'b0, isSub};

  // same operand signs, different result sign
  assign ovf64 = (a[DW-1] == bOp[DW-1]) && (full[DW-1] != a[DW-1]);
  assign ovf32 = (a[HW-1] == bOp[HW-1]) && (low[HW-1] != a[HW-1]);

  assign sum = is32 ? {{(DW-HW){1'b0}}, low[HW-1:0]} : full[DW-1:0];

  // carry out inverted on sub gives borrow
  assign carry = (is32 ? low[HW] : full[DW]) ^ isSub;
  assign overflow = is32 ? ovf32 : ovf64;
  assign auxCarry = nib[4] ^ isSub;

endmodule

`default_nettype wire

/* aluCondEval.sv */
// condition code check against a flag set, feeds cmov and cset in the ALU core
`default_nettype none
`timescale 1ns/10ps

`include "intAlu_settings.svh"

module aluCondEval (
  input  intAluPkg::aluFlags_t flags,
  input  intAluPkg::aluCond_e  cond,
  output logic                 take
);

  import intAluPkg::*;

  always_comb
  begin
    case (cond)
      Z:       take = flags.z;
      NZ:      take = ~flags.z;
      S:       take = flags.s;
      NS:      take = ~flags.s;
      UGT:     take = ~flags.c & ~flags.z;
      ULE:     take = flags.c | flags.z;
      UGE:     take = ~flags.c;
      ULT:     take = flags.c; // borrow set
      // signed compares via S vs O
      SGT:     take = ~flags.z & (flags.s == flags.o);
      SLE:     take = flags.z | (flags.s != flags.o);
      SGE:     take = flags.s == flags.o;
      SLT:     take = flags.s != flags.o;
      O:       take = flags.o;
      NO:      take = ~flags.o;
      P:       take = flags.p;
      NP:      take = ~flags.p;
      default: take = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* aluCore.sv */
// single-cycle integer ALU top, takes one request per clock and registers the response
`default_nettype none
`timescale 1ns/10ps

`include "intAlu_settings.svh"

module aluCore (
  input  logic                 clk,
  input  logic                 rst,
  input  intAluPkg::aluReq_t   req,
  output intAluPkg::aluResp_t  resp
);

  import intAluPkg::*;

  logic                       isSub;
  logic                       is32;
  logic                       addEn;
  logic                       condTake;
  logic [`ALU_DATA_WIDTH-1:0] sum;
  logic [`ALU_DATA_WIDTH-1:0] logicResult;
  logic [`ALU_DATA_WIDTH-1:0] result;
  logic                       adderCarry;
  logic                       adderOverflow;
  logic                       adderAux;
  logic                       writesFlags;
  aluFlags_t                  flagsNext;
  aluResp_t                   respNext;

  // adder op decode
  always_comb
  begin
    addEn = 1'b0;
    isSub = 1'b0;
    is32 = 1'b0;
    case (req.op)
      ADD64:   addEn = 1'b1;
      ADD32:
      begin
        addEn = 1'b1;
        is32 = 1'b1;
      end
      SUB64:
      begin
        addEn = 1'b1;
        isSub = 1'b1;
      end
      SUB32:
      begin
        addEn = 1'b1;
        isSub = 1'b1;
        is32 = 1'b1;
      end
      default: addEn = 1'b0;
    endcase
  end

  aluAdder adder (
    .a        (req.a),
    .b        (req.b),
    .isSub    (isSub),
    .is32     (is32),
    .sum      (sum),
    .carry    (adderCarry),
    .overflow (adderOverflow),
    .auxCarry (adderAux)
  );

  aluCondEval condEval (
    .flags (req.flagsIn),
    .cond  (req.cond),
    .take  (condTake)
  );

  aluLogicMove logicMove (
    .op       (req.op),
    .a        (req.a),
    .b        (req.b),
    .condTake (condTake),
    .result   (logicResult)
  );

  assign result = addEn ? sum : logicResult;

  aluFlagGen flagGen (
    .op            (req.op),
    .result        (result),
    .adderCarry    (adderCarry),
    .adderOverflow (adderOverflow),
    .adderAux      (adderAux),
    .flagsIn       (req.flagsIn),
    .flags         (flagsNext),
    .writesFlags   (writesFlags)
  );

  assign respNext.valid = req.valid;
  assign respNext.result = result;
  assign respNext.flags = flagsNext;
  assign respNext.flagsWrite = req.valid & req.setFlags & writesFlags;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resp.valid <= 1'b0;
      resp.result <= `ALU_RESET_RESULT;
      resp.flags <= `ALU_RESET_FLAGS;
      resp.flagsWrite <= 1'b0;
    end
    else
      resp <= respNext; // one cycle, no stall
  end

endmodule

`default_nettype wire

/* aluFlagGen.sv */
// builds the COASZP flag set and the flag-write qualifier for the executed ALU op
`default_nettype none
`timescale 1ns/10ps

`include "intAlu_settings.svh"

module aluFlagGen (
  input  intAluPkg::aluOp_e          op,
  input  logic [`ALU_DATA_WIDTH-1:0] result,
  input  logic                       adderCarry,
  input  logic                       adderOverflow,
  input  logic                       adderAux,
  input  intAluPkg::aluFlags_t       flagsIn,
  output intAluPkg::aluFlags_t       flags,
  output logic                       writesFlags
);

  import intAluPkg::*;

  localparam int DW = `ALU_DATA_WIDTH;
  localparam int HW = `ALU_HALF_WIDTH;

  logic isArith;
  logic isLogic;
  logic is32;
  logic sign;
  logic zero;
  logic parity;

  always_comb
  begin
    isArith = 1'b0;
    isLogic = 1'b0;
    is32 = 1'b0;
    case (op)
      ADD64, SUB64:                 isArith = 1'b1;
      ADD32, SUB32:
      begin
        isArith = 1'b1;
        is32 = 1'b1;
      end
      AND64, OR64, XOR64, XNOR64:   isLogic = 1'b1;
      AND32, OR32, XOR32, XNOR32:
      begin
        isLogic = 1'b1;
        is32 = 1'b1;
      end
      default:                      isArith = 1'b0;
    endcase
  end

  assign sign = is32 ? result[HW-1] : result[DW-1];
  assign zero = is32 ? (result[HW-1:0] == '0) : (result == '0);
  assign parity = ~^result[7:0]; // set on even bit count

  assign writesFlags = isArith | isLogic;

  always_comb
  begin
    flags = flagsIn; // moves and extends leave flags alone
    if (writesFlags)
    begin
      flags.c = isArith & adderCarry;
      flags.o = isArith & adderOverflow;
      flags.a = isArith & adderAux;
      flags.s = sign;
      flags.z = zero;
      flags.p = parity;
    end
  end

endmodule

`default_nettype wire

/* aluLogicMove.sv */
// non-adder result mux of the ALU core: logic ops, moves, extends, cmov and cset
`default_nettype none
`timescale 1ns/10ps

`include "intAlu_settings.svh"

module aluLogicMove (
  input  intAluPkg::aluOp_e          op,
  input  logic [`ALU_DATA_WIDTH-1:0] a,
  input  logic [`ALU_DATA_WIDTH-1:0] b,
  input  logic                       condTake,
  output logic [`ALU_DATA_WIDTH-1:0] result
);

  import intAluPkg::*;

  localparam int DW = `ALU_DATA_WIDTH;
  localparam int HW = `ALU_HALF_WIDTH;

  logic [DW-1:0] andV;
  logic [DW-1:0] orV;
  logic [DW-1:0] xorV;

  // keep the low half, clear the upper bits
  function automatic logic [DW-1:0] lowHalf(input logic [DW-1:0] v);
    lowHalf = {{(DW-HW){1'b0}}, v[HW-1:0]};
  endfunction

  assign andV = a & b;
  assign orV = a | b;
  assign xorV = a ^ b;

  always_comb
  begin
    case (op)
      AND64:   result = andV;
      AND32:   result = lowHalf(andV);
      OR64:    result = orV;
      OR32:    result = lowHalf(orV);
      XOR64:   result = xorV;
      XOR32:   result = lowHalf(xorV);
      XNOR64:  result = ~xorV;
      XNOR32:  result = lowHalf(~xorV);
      MOV64:   result = b;
      MOV32:   result = lowHalf(b);
      ZXT8:    result = {{(DW-8){1'b0}}, b[7:0]};
      ZXT16:   result = {{(DW-16){1'b0}}, b[15:0]};
      SXT8:    result = {{(DW-8){b[7]}}, b[7:0]};
      SXT16:   result = {{(DW-16){b[15]}}, b[15:0]};
      SXT32:   result = {{(DW-HW){b[HW-1]}}, b[HW-1:0]};
      CMOV:    result = condTake ? b : a;
      CSET:    result = {{(DW-1){1'b0}}, condTake};
      default: result = '0; // adder ops, sum taken in the core
    endcase
  end

endmodule

`default_nettype wire

/* intAlu.f */
+incdir+.
intAluPkg.sv
aluCondEval.sv
aluAdder.sv
aluLogicMove.sv
aluFlagGen.sv
aluCore.sv
intAlu_checker.sv
intAluTb.sv

/* intAluPkg.sv */
// opcode, condition and bus types of the integer ALU, imported by the RTL and the testbench
`default_nettype none

`include "intAlu_settings.svh"

package intAluPkg;

  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ADD64,
    ADD32,
    SUB64,
    SUB32,
    AND64,
    AND32,
    OR64,
    OR32,
    XOR64,
    XOR32,
    XNOR64,
    XNOR32,
    MOV64,
    MOV32,
    ZXT8,
    ZXT16,
    SXT8,
    SXT16,
    SXT32,
    CMOV,
    CSET
  } aluOp_e;

  // x86 style condition codes
  typedef enum logic [`ALU_COND_WIDTH-1:0] {
    Z, NZ, S, NS,
    UGT, ULE, UGE, ULT,
    SGT, SLE, SGE, SLT,
    O, NO, P, NP
  } aluCond_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a; // aux carry out of bit 3
    logic s;
    logic z;
    logic p;
  } aluFlags_t;

  typedef struct packed {
    logic                       valid;
    aluOp_e                     op;
    aluCond_e                   cond;
    logic                       setFlags; // instruction asks for a flag update
    logic [`ALU_DATA_WIDTH-1:0] a;
    logic [`ALU_DATA_WIDTH-1:0] b;
    aluFlags_t                  flagsIn;
  } aluReq_t;

  typedef struct packed {
    logic                       valid;
    logic [`ALU_DATA_WIDTH-1:0] result;
    aluFlags_t                  flags;
    logic                       flagsWrite;
  } aluResp_t;

endpackage

`default_nettype wire

/* intAluTb.sv */
// directed-test testbench of the integer ALU, drives aluCore and checks it against a rule model
`timescale 1ns/10ps
`default_nettype none

`include "intAlu_settings.svh"

module intAluTb;

  import intAluPkg::*;

  localparam int cornerCount = 8;
  localparam int addRandCount = 100;
  localparam int logicRandCount = 16;
  localparam int moveRandCount = 12;
  localparam int csetRandCount = 8;
  localparam int cmovCount = 48;
  localparam int streamCount = 160;
  localparam int resetCycles = 3;
  localparam int testCycles = resetCycles
    + 4 * cornerCount * cornerCount + addRandCount + 1
    + 8 * logicRandCount + 1 + 7 * moveRandCount + 1
    + 16 * csetRandCount + 1 + cmovCount + 1
    + streamCount + resetCycles + 2;
  localparam int cycleLimit = testCycles * 3 / 2;

  logic     clk = 1'b1;
  logic     rst;
  aluReq_t  req;
  aluResp_t resp;
  aluResp_t expected;   // response due at the next falling edge
  aluOp_e   expectedOp;
  logic     expectActive = 1'b0;
  logic     expectReset = 1'b0;
  aluReq_t  idle;
  int       cycleCount = 0;
  int       resultErrors = 0;
  int       flagErrors = 0;
  int       controlErrors = 0;

  always #2 clk = ~clk;

  aluCore DUT (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .resp (resp)
  );

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycleCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic condHolds(input aluFlags_t f, input aluCond_e c);
    case (c)
      Z:       return f.z;
      NZ:      return !f.z;
      S:       return f.s;
      NS:      return !f.s;
      UGT:     return !f.c && !f.z;
      ULE:     return f.c || f.z;
      UGE:     return !f.c;
      ULT:     return f.c;
      SGT:     return !f.z && (f.s == f.o);
      SLE:     return f.z || (f.s != f.o);
      SGE:     return f.s == f.o;
      SLT:     return f.s != f.o;
      O:       return f.o;
      NO:      return !f.o;
      P:       return f.p;
      NP:      return !f.p;
      default: return 1'b0;
    endcase
  endfunction

  // low w bits as a 65-bit signed value
  function automatic logic [64:0] signExt(input logic [63:0] v, input int w);
    return (w == 32) ? {{33{v[31]}}, v[31:0]} : {v[63], v};
  endfunction

  function automatic aluResp_t modelResp(input aluReq_t r);
    aluResp_t    e;
    logic [63:0] mask;
    logic [64:0] wide;
    logic [64:0] swide;
    logic        arith;
    logic        logicOp;
    int          w;
    e.valid = r.valid;
    e.flags = r.flagsIn;
    w = (r.op inside {ADD32, SUB32, AND32, OR32, XOR32, XNOR32, MOV32}) ? 32 : 64;
    mask = (w == 32) ? 64'h0000_0000_ffff_ffff : '1;
    arith = r.op inside {ADD64, ADD32, SUB64, SUB32};
    logicOp = r.op inside {AND64, AND32, OR64, OR32, XOR64, XOR32, XNOR64, XNOR32};
    swide = '0;
    case (r.op)
      ADD64, ADD32:
      begin
        wide = {1'b0, r.a & mask} + {1'b0, r.b & mask};
        swide = signExt(r.a, w) + signExt(r.b, w);
        e.flags.c = wide[w];
        e.flags.a = ({1'b0, r.a[3:0]} + {1'b0, r.b[3:0]}) > 5'd15;
      end
      SUB64, SUB32:
      begin
        wide = {1'b0, r.a & mask} - {1'b0, r.b & mask};
        swide = signExt(r.a, w) - signExt(r.b, w);
        e.flags.c = (r.a & mask) < (r.b & mask); // borrow
        e.flags.a = r.a[3:0] < r.b[3:0];
      end
      AND64, AND32:   wide = {1'b0, r.a & r.b};
      OR64, OR32:     wide = {1'b0, r.a | r.b};
      XOR64, XOR32:   wide = {1'b0, r.a ^ r.b};
      XNOR64, XNOR32: wide = {1'b0, ~(r.a ^ r.b)};
      MOV64, MOV32:   wide = {1'b0, r.b};
      ZXT8:           wide = {57'b0, r.b[7:0]};
      ZXT16:          wide = {49'b0, r.b[15:0]};
      SXT8:           wide = {1'b0, {56{r.b[7]}}, r.b[7:0]};
      SXT16:          wide = {1'b0, {48{r.b[15]}}, r.b[15:0]};
      SXT32:          wide = {1'b0, {32{r.b[31]}}, r.b[31:0]};
      CMOV:           wide = {1'b0, condHolds(r.flagsIn, r.cond) ? r.b : r.a};
      CSET:           wide = {64'b0, condHolds(r.flagsIn, r.cond)};
      default:        wide = '0;
    endcase
    e.result = wide[63:0] & mask;
    if (arith || logicOp)
    begin
      e.flags.o = arith && (swide[w] != swide[w-1]);
      e.flags.s = e.result[w-1];
      e.flags.z = e.result == '0;
      e.flags.p = ($countones(e.result[7:0]) % 2) == 0;
      if (logicOp)
      begin
        e.flags.c = 1'b0;
        e.flags.a = 1'b0;
      end
    end
    e.flagsWrite = r.valid && r.setFlags && (arith || logicOp);
    return e;
  endfunction

  function automatic aluReq_t randomReq(input aluOp_e op);
    aluReq_t r;
    r.valid = 1'b1;
    r.op = op;
    r.cond = aluCond_e'(4'($urandom));
    r.setFlags = 1'($urandom);
    r.a = {$urandom(), $urandom()};
    r.b = {$urandom(), $urandom()};
    r.flagsIn = aluFlags_t'(6'($urandom));
    return r;
  endfunction

  function automatic logic [63:0] cornerValue(input int i);
    case (i)
      0:       return 64'h0;
      1:       return 64'h1;
      2:       return 64'hffff_ffff_ffff_ffff;
      3:       return 64'h7fff_ffff_ffff_ffff;
      4:       return 64'h8000_0000_0000_0000;
      5:       return 64'h0000_0000_ffff_ffff;
      6:       return 64'h0000_0000_7fff_ffff;
      default: return 64'h0000_0000_8000_000f;
    endcase
  endfunction

  task automatic checkResult(input logic [`ALU_DATA_WIDTH-1:0] got,
                             input logic [`ALU_DATA_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      resultErrors++;
      $display("Error: resp.result = %h, expected %h, op %s", got, exp, expectedOp.name());
    end
  endtask

  task automatic checkFlags(input aluFlags_t got, input aluFlags_t exp);
    if (got !== exp)
    begin
      flagErrors++;
      $display("Error: resp.flags = %h, expected %h, op %s", got, exp, expectedOp.name());
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      controlErrors++;
      $display("Error: %s = %h, expected %h, op %s", name, got, exp, expectedOp.name());
    end
  endtask

  // one clock: check what the last edge registered, then drive the next request
  task automatic stepCycle(input aluReq_t r, input logic rstIn);
    @(negedge clk);
    if (expectActive)
    begin
      checkBit("resp.valid", resp.valid, expected.valid);
      checkBit("resp.flagsWrite", resp.flagsWrite, expected.flagsWrite);
      if (expected.valid || expectReset)
      begin
        checkResult(resp.result, expected.result);
        checkFlags(resp.flags, expected.flags);
      end
    end
    rst = rstIn;
    req = r;
    expectActive = 1'b1;
    expectReset = rstIn;
    expectedOp = r.op;
    expected = rstIn ? '0 : modelResp(r);
  endtask

  task automatic testAddSub();
    aluReq_t r;
    for (int k = 0; k < 4; k++)
      for (int i = 0; i < cornerCount; i++)
        for (int j = 0; j < cornerCount; j++)
        begin
          r = randomReq(aluOp_e'(5'(ADD64 + k)));
          r.a = cornerValue(i);
          r.b = cornerValue(j);
          r.setFlags = 1'((i + j) % 2);
          stepCycle(r, 1'b0);
        end
    for (int n = 0; n < addRandCount; n++)
      stepCycle(randomReq(aluOp_e'(5'($urandom % 4))), 1'b0);
    stepCycle(idle, 1'b0);
  endtask

  task automatic testLogic();
    for (int k = 0; k < 8; k++)
      for (int n = 0; n < logicRandCount; n++)
        stepCycle(randomReq(aluOp_e'(5'(AND64 + k))), 1'b0);
    stepCycle(idle, 1'b0);
  endtask

  task automatic testMoves();
    for (int k = 0; k < 7; k++)
      for (int n = 0; n < moveRandCount; n++)
        stepCycle(randomReq(aluOp_e'(5'(MOV64 + k))), 1'b0); // MOV64 up to SXT32
    stepCycle(idle, 1'b0);
  endtask

  task automatic testCset();
    aluReq_t r;
    for (int c = 0; c < 16; c++)
      for (int n = 0; n < csetRandCount; n++)
      begin
        r = randomReq(CSET);
        r.cond = aluCond_e'(4'(c));
        stepCycle(r, 1'b0);
      end
    stepCycle(idle, 1'b0);
  endtask

  task automatic testCmov();
    for (int n = 0; n < cmovCount; n++)
      stepCycle(randomReq(CMOV), 1'b0);
    stepCycle(idle, 1'b0);
  endtask

  task automatic testStream();
    aluReq_t r;
    for (int i = 0; i < streamCount; i++)
    begin
      if (i == streamCount / 2)
      begin
        for (int k = 0; k < resetCycles; k++)
          stepCycle(randomReq(aluOp_e'(5'($urandom % 21))), 1'b1);
        stepCycle(idle, 1'b0); // first cycle out of reset
      end
      r = randomReq(aluOp_e'(5'($urandom % 21)));
      r.valid = ($urandom % 8) != 0;
      stepCycle(r, 1'b0);
    end
    stepCycle(idle, 1'b0);
  endtask

  initial
  begin
    void'($urandom(32'h1594));
    rst = 1'b1;
    req = '0;
    idle = '0;
    for (int k = 0; k < resetCycles; k++)
      stepCycle(idle, 1'b1);
    testAddSub();
    testLogic();
    testMoves();
    testCset();
    testCmov();
    testStream();
    $display("errors: result %0d, flags %0d, control %0d",
             resultErrors, flagErrors, controlErrors);
    if (resultErrors + flagErrors + controlErrors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* intAlu_checker.sv */
// concurrent assertions on the ALU response register, bound into every aluCore instance
`timescale 1ns/10ps
`default_nettype none

module intAluChecker (
  input logic                clk,
  input logic                rst,
  input intAluPkg::aluReq_t  req,
  input intAluPkg::aluResp_t resp
);

  import intAluPkg::*;

  validLowAfterReset: assert property (@(posedge clk) rst |=> !resp.valid)
    else $error("resp.valid high in the cycle after reset");

  // one cycle latency, no stall
  validFollowsReq: assert property (@(posedge clk) !rst |=> resp.valid == $past(req.valid))
    else $error("resp.valid does not follow req.valid by one cycle");

  writeNeedsValid: assert property (@(posedge clk) resp.flagsWrite |-> resp.valid)
    else $error("resp.flagsWrite high without resp.valid");

  resultKnown: assert property (@(posedge clk) resp.valid |-> !$isunknown(resp.result))
    else $error("resp.result has X bits on a valid response");

endmodule

bind aluCore intAluChecker assertCheck (
  .clk  (clk),
  .rst  (rst),
  .req  (req),
  .resp (resp)
);

`default_nettype wire

/* intAlu_settings.svh */
// fixed ALU widths and reset values, `include wherever the ALU types or datapath need them
`ifndef INTALU_SETTINGS_SVH
`define INTALU_SETTINGS_SVH

// operand and result width
`define ALU_DATA_WIDTH 64

// width of the 32-bit op forms
`define ALU_HALF_WIDTH 32

// C O A S Z P
`define ALU_FLAG_WIDTH 6

`define ALU_COND_WIDTH 4
`define ALU_OP_WIDTH 5

// response register contents after reset
`define ALU_RESET_RESULT {`ALU_DATA_WIDTH{1'b0}}
`define ALU_RESET_FLAGS {`ALU_FLAG_WIDTH{1'b0}}

`endif

/* run.sh */
#!/bin/sh
# build the intAlu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module intAluTb -f intAlu.f -o intAluSim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/intAluSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
